// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_rv_core
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               run,
    input  logic               prog_we,
    input  logic [imem_aw-1:0] prog_addr,
    input  logic [xlen-1:0]    prog_data,
    output retire_t            retire
);

    logic [xlen-1:0]    pc;
    logic [xlen-1:0]    instr;
    exe_bundle_t        exe;
    res_bundle_t        res;
    fwd_t               fwd;
    redirect_t          redirect;
    wb_t                wb;
    logic [dmem_aw-1:0] dmem_addr;
    logic               dmem_we;
    logic [xlen-1:0]    dmem_wdata;
    logic [xlen-1:0]    dmem_rdata;

    // fetch, decode and register read
    rv_decode i_rv_decode (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .run      (run),
        .instr    (instr),
        .pc       (pc),
        .fwd      (fwd),
        .redirect (redirect),
        .wb       (wb),
        .exe      (exe)
    );

    // alu, branches and memory request
    rv_execute i_rv_execute (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .exe        (exe),
        .res        (res),
        .fwd        (fwd),
        .redirect   (redirect),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata)
    );

    // load data, writeback, retire
    rv_result i_rv_result (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .res        (res),
        .dmem_rdata (dmem_rdata),
        .wb         (wb),
        .retire     (retire)
    );

    rv_imem i_rv_imem (
        .CLK       (CLK),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .instr     (instr)
    );

    rv_dmem i_rv_dmem (
        .CLK   (CLK),
        .we    (dmem_we),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

endmodule

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  logic            CLK,
    input  logic            rst_n,
    input  logic            run,
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] pc,
    input  fwd_t            fwd,
    input  redirect_t       redirect,
    input  wb_t             wb,
    output exe_bundle_t     exe
);

    // 32 x xlen register file, x0 never written
    logic [xlen-1:0] regs [32];

    opcode_e         opcode;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd_f;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            stall;
    logic            issue;
    exe_bundle_t     exe_d;

    // execute beats result beats register file
    function automatic logic [xlen-1:0] read_src(
        input logic [4:0]      rs,
        input fwd_t            f,
        input wb_t             w,
        input logic [xlen-1:0] rf
    );
        if (rs == 5'd0)
            return '0;
        else if (f.valid && f.rd == rs)
            return f.value;
        else if (w.valid && w.rd == rs)
            return w.value;
        else
            return rf;
    endfunction

    // funct3 to alu op, alt picks sub or sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // instruction fields
    assign opcode = opcode_e'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd_f   = instr[11:7];
    assign funct3 = instr[14:12];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign rs1_val = read_src(rs1, fwd, wb, regs[rs1]);
    assign rs2_val = read_src(rs2, fwd, wb, regs[rs2]);

    // which sources really get read
    assign uses_rs1 = opcode inside {opc_op, opc_op_imm, opc_load, opc_store, opc_branch};
    assign uses_rs2 = opcode inside {opc_op, opc_store, opc_branch};

    // load in execute, data not ready until result
    assign stall = fwd.valid && fwd.is_load && fwd.rd != 5'd0 &&
                   ((uses_rs1 && fwd.rd == rs1) || (uses_rs2 && fwd.rd == rs2));

    // redirect flushes whatever sits in decode
    assign issue = run && !stall && !redirect.taken;

    always_comb begin
        exe_d            = '0;
        exe_d.valid      = issue;
        exe_d.pc         = pc;
        exe_d.op_a       = rs1_val;
        exe_d.op_b       = rs2_val;
        exe_d.store_data = rs2_val;
        exe_d.imm        = imm_i;
        exe_d.alu_op     = alu_add;
        exe_d.funct3     = funct3;
        case (opcode)
            opc_op: begin
                exe_d.alu_op = alu_sel(funct3, instr[30]);
                exe_d.rd     = rd_f;
            end
            opc_op_imm: begin
                // only the shift-right form looks at bit 30
                exe_d.alu_op  = alu_sel(funct3, instr[30] && funct3 == 3'b101);
                exe_d.use_imm = 1'b1;
                exe_d.rd      = rd_f;
            end
            opc_lui: begin
                exe_d.alu_op  = alu_pass_b;
                exe_d.use_imm = 1'b1;
                exe_d.imm     = imm_u;
                exe_d.rd      = rd_f;
            end
            opc_load: begin
                exe_d.is_load = 1'b1;
                exe_d.use_imm = 1'b1;
                exe_d.rd      = rd_f;
            end
            opc_store: begin
                exe_d.is_store = 1'b1;
                exe_d.use_imm  = 1'b1;
                exe_d.imm      = imm_s;
            end
            opc_branch: begin
                exe_d.is_branch = 1'b1;
                exe_d.imm       = imm_b;
            end
            opc_jal: begin
                exe_d.is_jal = 1'b1;
                exe_d.imm    = imm_j;
                exe_d.rd     = rd_f;
            end
            // unknown opcode passes through without a register write
            default: exe_d.rd = 5'd0;
        endcase
    end

    // pc holds on stall and while run is low
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else if (issue) begin
            pc <= pc + xlen'(4);
        end
    end

    // write port from result stage
    always_ff @(posedge CLK) begin
        if (wb.valid)
            regs[wb.rd] <= wb.value;
    end

    // stage register into execute, only valid is cleared
    always_ff @(posedge CLK) begin
        exe <= exe_d;
        if (!rst_n)
            exe.valid <= 1'b0;
    end

endmodule

// ==== design/rv_dmem.sv ====
`timescale 1ns/1ps

module rv_dmem import rv_pkg::*; (
    input  logic               CLK,
    input  logic               we,
    input  logic [dmem_aw-1:0] addr,
    input  logic [xlen-1:0]    wdata,
    output logic [xlen-1:0]    rdata
);

    logic [xlen-1:0] mem [dmem_words];

    // store from execute
    always_ff @(posedge CLK) begin
        if (we)
            mem[addr] <= wdata;
    end

    // read lands one clock later in the result stage
    always_ff @(posedge CLK) begin
        rdata <= mem[addr];
    end

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    input  exe_bundle_t        exe,
    output res_bundle_t        res,
    output fwd_t               fwd,
    output redirect_t          redirect,
    output logic [dmem_aw-1:0] dmem_addr,
    output logic               dmem_we,
    output logic [xlen-1:0]    dmem_wdata
);

    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] value;
    logic [4:0]      shamt;
    logic            br_cond;
    res_bundle_t     res_d;

    // immediate or rs2
    assign opb   = exe.use_imm ? exe.imm : exe.op_b;
    assign shamt = opb[4:0];

    always_comb begin
        case (exe.alu_op)
            alu_add:    alu_y = exe.op_a + opb;
            alu_sub:    alu_y = exe.op_a - opb;
            alu_and:    alu_y = exe.op_a & opb;
            alu_or:     alu_y = exe.op_a | opb;
            alu_xor:    alu_y = exe.op_a ^ opb;
            alu_slt:    alu_y = xlen'($signed(exe.op_a) < $signed(opb));
            alu_sltu:   alu_y = xlen'(exe.op_a < opb);
            alu_sll:    alu_y = exe.op_a << shamt;
            alu_srl:    alu_y = exe.op_a >> shamt;
            alu_sra:    alu_y = $signed(exe.op_a) >>> shamt;
            alu_pass_b: alu_y = opb;
            default:    alu_y = exe.op_a + opb;
        endcase
    end

    // compare always uses rs2, never the immediate
    always_comb begin
        case (exe.funct3)
            br_beq:  br_cond = exe.op_a == exe.op_b;
            br_bne:  br_cond = exe.op_a != exe.op_b;
            br_blt:  br_cond = $signed(exe.op_a) < $signed(exe.op_b);
            br_bge:  br_cond = $signed(exe.op_a) >= $signed(exe.op_b);
            default: br_cond = 1'b0;
        endcase
    end

    // jal links pc+4
    assign value = exe.is_jal ? exe.pc + xlen'(4) : alu_y;

    assign redirect.taken  = exe.valid && (exe.is_jal || (exe.is_branch && br_cond));
    assign redirect.target = exe.pc + exe.imm;

    // bypass to decode, load value here is only the address
    assign fwd.valid   = exe.valid;
    assign fwd.is_load = exe.is_load;
    assign fwd.rd      = exe.rd;
    assign fwd.value   = value;

    // word index from the adder
    assign dmem_addr  = alu_y[dmem_aw+1:2];
    assign dmem_we    = exe.valid && exe.is_store;
    assign dmem_wdata = exe.store_data;

    always_comb begin
        res_d.valid   = exe.valid;
        res_d.pc      = exe.pc;
        res_d.rd      = exe.rd;
        res_d.value   = value;
        res_d.is_load = exe.is_load;
    end

    // stage register into result
    always_ff @(posedge CLK) begin
        res <= res_d;
        if (!rst_n)
            res.valid <= 1'b0;
    end

endmodule

// ==== design/rv_imem.sv ====
`timescale 1ns/1ps

module rv_imem import rv_pkg::*; (
    input  logic               CLK,
    input  logic               prog_we,
    input  logic [imem_aw-1:0] prog_addr,
    input  logic [xlen-1:0]    prog_data,
    input  logic [xlen-1:0]    pc,
    output logic [xlen-1:0]    instr
);

    logic [xlen-1:0] mem [imem_words];

    // program load port
    always_ff @(posedge CLK) begin
        if (prog_we)
            mem[prog_addr] <= prog_data;
    end

    // combinational fetch, word aligned
    assign instr = mem[pc[imem_aw+1:2]];

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

    // datapath width
    localparam int xlen = 32;

    // instruction memory geometry
    localparam int imem_words = 256;
    localparam int imem_aw = 8;

    // data memory geometry
    localparam int dmem_words = 256;
    localparam int dmem_aw = 8;

    // branch funct3 codes
    localparam logic [2:0] br_beq = 3'b000;
    localparam logic [2:0] br_bne = 3'b001;
    localparam logic [2:0] br_blt = 3'b100;
    localparam logic [2:0] br_bge = 3'b101;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    // alu functions
    // pass_b routes operand b straight through for lui
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] op_a;
        logic [xlen-1:0] op_b;
        logic [xlen-1:0] store_data;
        logic [xlen-1:0] imm;
        logic [4:0]      rd;
        alu_op_e         alu_op;
        logic            is_load;
        logic            is_store;
        logic            is_branch;
        logic            is_jal;
        logic            use_imm;
        logic [2:0]      funct3;
    } exe_bundle_t;

    // execute to result
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] value;
        logic            is_load;
    } res_bundle_t;

    // writeback, also the result stage bypass
    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [xlen-1:0] value;
    } wb_t;

    // execute stage bypass and load-use flag
    typedef struct packed {
        logic            valid;
        logic            is_load;
        logic [4:0]      rd;
        logic [xlen-1:0] value;
    } fwd_t;

    // taken branch or jal
    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    // one completed instruction
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] value;
    } retire_t;

endpackage

// ==== design/rv_result.sv ====
`timescale 1ns/1ps

module rv_result import rv_pkg::*; (
    input  logic            CLK,
    input  logic            rst_n,
    input  res_bundle_t     res,
    input  logic [xlen-1:0] dmem_rdata,
    output wb_t             wb,
    output retire_t         retire
);

    logic [xlen-1:0] value;

    // load data arrives from the registered dmem read
    assign value = res.is_load ? dmem_rdata : res.value;

    // x0 writes are dropped
    assign wb.valid = res.valid && res.rd != 5'd0;
    assign wb.rd    = res.rd;
    assign wb.value = value;

    // every valid bundle retires
    assign retire.valid = res.valid;
    assign retire.pc    = res.pc;
    assign retire.rd    = res.rd;
    assign retire.value = value;

endmodule

// ==== filelist.f ====
design/rv_pkg.sv
design/rv_imem.sv
design/rv_dmem.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core_top.sv
test/tb_clock.sv
test/tb_rv_core.sv

// ==== test/rv_vectors.txt ====
# P <word>             program word in hex, in address order from 0
# R <pc> <rd> <value>  expected retire in order, hex; value is ignored when rd is 0
P 123450B7  # 00 lui   x1, 0x12345
P FFB00113  # 04 addi  x2, x0, -5
P 67808193  # 08 addi  x3, x1, 0x678
P 00218233  # 0c add   x4, x3, x2
P 403202B3  # 10 sub   x5, x4, x3
P 0002A333  # 14 slt   x6, x5, x0
P 0042B3B3  # 18 sltu  x7, x5, x4
P FFC12413  # 1c slti  x8, x2, -4
P FFF23493  # 20 sltiu x9, x4, -1
P 0030C533  # 24 xor   x10, x1, x3
P 006565B3  # 28 or    x11, x10, x6
P 0F01F613  # 2c andi  x12, x3, 0xf0
P 006096B3  # 30 sll   x13, x1, x6
P 00415713  # 34 srli  x14, x2, 4
P 40115793  # 38 srai  x15, x2, 1
P 0082D833  # 3c srl   x16, x5, x8
P 4082D8B3  # 40 sra   x17, x5, x8
P FFF54913  # 44 xori  x18, x10, -1
P 01F31993  # 48 slli  x19, x6, 31
P 00302823  # 4c sw    x3, 16(x0)
P 00202A23  # 50 sw    x2, 20(x0)
P 01002A03  # 54 lw    x20, 16(x0)
P 01402A83  # 58 lw    x21, 20(x0)
P 014A8B33  # 5c add   x22, x21, x20
P 01602C23  # 60 sw    x22, 24(x0)
P 01802B83  # 64 lw    x23, 24(x0)
P 01002C03  # 68 lw    x24, 16(x0)
P 018A0463  # 6c beq   x20, x24, +8
P 00100C93  # 70 addi  x25, x0, 1
P 018A1463  # 74 bne   x20, x24, +8
P 00200C93  # 78 addi  x25, x0, 2
P 00614463  # 7c blt   x2, x6, +8
P 00300D13  # 80 addi  x26, x0, 3
P 00615463  # 84 bge   x2, x6, +8
P 00400D13  # 88 addi  x26, x0, 4
P 00234463  # 8c blt   x6, x2, +8
P 00235463  # 90 bge   x6, x2, +8
P 00500D93  # 94 addi  x27, x0, 5
P 01AC9463  # 98 bne   x25, x26, +8
P 00600D93  # 9c addi  x27, x0, 6
P 00C000EF  # a0 jal   x1, +12
P 00700E13  # a4 addi  x28, x0, 7
P 00800E13  # a8 addi  x28, x0, 8
P 00408E93  # ac addi  x29, x1, 4
P 00200F13  # b0 addi  x30, x0, 2
P FFFF0F13  # b4 addi  x30, x30, -1
P FE0F1EE3  # b8 bne   x30, x0, -4
P 01EE8FB3  # bc add   x31, x29, x30
P 0000006F  # c0 jal   x0, 0
# alu and lui
R 00 01 12345000
R 04 02 FFFFFFFB
R 08 03 12345678
R 0C 04 12345673
R 10 05 FFFFFFFB
R 14 06 00000001
R 18 07 00000000
R 1C 08 00000001
R 20 09 00000001
R 24 0A 00000678
R 28 0B 00000679
R 2C 0C 00000070
R 30 0D 2468A000
R 34 0E 0FFFFFFF
R 38 0F FFFFFFFD
R 3C 10 7FFFFFFD
R 40 11 FFFFFFFD
R 44 12 FFFFF987
R 48 13 80000000
# stores and loads, 5c waits on the load before it
R 4C 00 00000000
R 50 00 00000000
R 54 14 12345678
R 58 15 FFFFFFFB
R 5C 16 12345673
R 60 00 00000000
R 64 17 12345673
R 68 18 12345678
# branches, wrong path never retires
R 6C 00 00000000
R 74 00 00000000
R 78 19 00000002
R 7C 00 00000000
R 84 00 00000000
R 88 1A 00000004
R 8C 00 00000000
R 90 00 00000000
R 98 00 00000000
# jal links pc+4
R A0 01 000000A4
R AC 1D 000000A8
# short backward loop, then halt
R B0 1E 00000002
R B4 1E 00000001
R B8 00 00000000
R B4 1E 00000000
R B8 00 00000000
R BC 1F 000000A8
R C0 00 00000000

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic CLK
);

    // 8 ns period, starts low
    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    logic               CLK;
    logic               rst_n;
    logic               run;
    logic               prog_we;
    logic [imem_aw-1:0] prog_addr;
    logic [xlen-1:0]    prog_data;
    retire_t            retire;

    // program image and expected retire list from the vector file
    logic [xlen-1:0] prog_q  [$];
    logic [xlen-1:0] exp_pc  [$];
    logic [4:0]      exp_rd  [$];
    logic [xlen-1:0] exp_val [$];

    int   errors;
    int   checked;
    int   wd_cycles;
    logic wd_armed;

    tb_clock i_tb_clock (
        .CLK (CLK)
    );

    rv_core_top i_rv_core_top (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .retire    (retire)
    );

    // tags P and R, '#' starts a comment up to end of line
    task automatic read_vectors();
        int              fd;
        int              n;
        int              c;
        logic [7:0]      tag;
        logic [xlen-1:0] f0;
        logic [xlen-1:0] f1;
        logic [xlen-1:0] f2;
        fd = $fopen("test/rv_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/rv_vectors.txt");
            errors++;
        end else begin
            n = $fscanf(fd, " %c", tag);
            while (n == 1) begin
                if (tag == "#") begin
                    // skip to newline (10) or end of file
                    c = $fgetc(fd);
                    while (c != 10 && c != -1)
                        c = $fgetc(fd);
                end else if (tag == "P") begin
                    if ($fscanf(fd, "%h", f0) == 1)
                        prog_q.push_back(f0);
                end else if (tag == "R") begin
                    if ($fscanf(fd, "%h %h %h", f0, f1, f2) == 3) begin
                        exp_pc.push_back(f0);
                        exp_rd.push_back(f1[4:0]);
                        exp_val.push_back(f2);
                    end
                end else begin
                    $display("unknown tag in vector file, character code %0d", tag);
                    errors++;
                end
                n = $fscanf(fd, " %c", tag);
            end
            $fclose(fd);
        end
    endtask

    // reset and program load, no retire may show up meanwhile
    task automatic load_program();
        int load_cycles;
        load_cycles = (prog_q.size() > 5) ? prog_q.size() : 5;
        for (int i = 0; i < load_cycles; i++) begin
            @(posedge CLK);
            if (i < prog_q.size()) begin
                prog_we   <= 1'b1;
                prog_addr <= imem_aw'(i);
                prog_data <= prog_q[i];
            end else begin
                prog_we <= 1'b0;
            end
            // five edges see rst_n low
            if (i == 4)
                rst_n <= 1'b1;
            @(negedge CLK);
            assert (retire.valid === 1'b0) else begin
                $display("ERR retire.valid expected 0 actual %h in load cycle %0d",
                         retire.valid, i);
                errors++;
            end
        end
        @(posedge CLK);
        prog_we <= 1'b0;
        rst_n   <= 1'b1;
        @(posedge CLK);
        run <= 1'b1;
    endtask

    // one retire pulse against the next expected record
    task automatic check_retire();
        logic [xlen-1:0] e_pc;
        logic [4:0]      e_rd;
        logic [xlen-1:0] e_val;
        e_pc  = exp_pc[checked];
        e_rd  = exp_rd[checked];
        e_val = exp_val[checked];
        assert (retire.pc === e_pc) else begin
            $display("ERR retire.pc record %0d expected %h actual %h",
                     checked, e_pc, retire.pc);
            errors++;
        end
        assert (retire.rd === e_rd) else begin
            $display("ERR retire.rd record %0d expected %h actual %h",
                     checked, e_rd, retire.rd);
            errors++;
        end
        // x0 has no architectural result to compare
        if (e_rd != 5'd0) begin
            assert (retire.value === e_val) else begin
                $display("ERR retire.value record %0d expected %h actual %h",
                         checked, e_val, retire.value);
                errors++;
            end
        end
        checked++;
    endtask

    // sample at the falling edge, away from the DUT's clock edge
    task automatic run_program();
        while (checked < exp_pc.size()) begin
            @(negedge CLK);
            if (retire.valid === 1'b1)
                check_retire();
            // last word is a jal to itself
            // dropping run here lets it retire exactly once
            if (checked == exp_pc.size() - 1 && run === 1'b1) begin
                @(posedge CLK);
                run <= 1'b0;
            end
        end
    endtask

    // nothing may retire after the expected list
    task automatic drain_check();
        repeat (8) begin
            @(negedge CLK);
            assert (retire.valid === 1'b0) else begin
                $display("ERR retire.valid expected 0 actual %h past last record, pc %h",
                         retire.valid, retire.pc);
                errors++;
            end
        end
    endtask

    task automatic end_run();
        $display("errors %0d, retire records checked %0d of %0d",
                 errors, checked, exp_pc.size());
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        errors    = 0;
        checked   = 0;
        wd_cycles = 0;
        wd_armed  = 1'b0;
        read_vectors();
        if (prog_q.size() == 0 || exp_pc.size() == 0) begin
            $display("vector file holds no program or no expected records");
            errors++;
            end_run();
        end else begin
            wd_cycles = prog_q.size() + 4 * exp_pc.size() + 20;
            wd_armed  = 1'b1;
            load_program();
            run_program();
            drain_check();
            end_run();
        end
    end

    // watchdog, budget scales with program and record count
    initial begin
        wait (wd_armed === 1'b1);
        repeat (wd_cycles) @(posedge CLK);
        $display("timeout: retirement stalled after %0d of %0d records",
                 checked, exp_pc.size());
        errors++;
        end_run();
    end

endmodule
